// File: audio_pkg.sv
`default_nettype none

package audio_pkg;

	// codec word width
	localparam int SAMPLE_W = 16;

	// word address of the 1M x 16 SRAM
	localparam int ADDR_W = 20;

	// speed switch field, factor is the field value plus one
	localparam int SPEED_W = 4;

	// controller states
	typedef enum logic [2:0] {
		ST_IDLE,
		ST_RECORD,
		ST_RECORD_PAUSE,
		ST_PLAY,
		ST_PLAY_PAUSE
	} rec_state_t;

	// playback modes, latched when play starts
	typedef enum logic [1:0] {
		MODE_NORMAL,
		MODE_FAST,
		MODE_SLOW_REPEAT,
		MODE_SLOW_INTERP
	} play_mode_t;

endpackage

`default_nettype wire

// File: debounce.sv
`default_nettype none

module debounce #(
	parameter int DEBOUNCE_CYCLES = 16
) (
	input  logic i_clk,
	input  logic i_rst_n,
	input  logic i_in,
	output logic o_neg
);

	localparam int CNT_W = $clog2(DEBOUNCE_CYCLES + 1);

	logic [1:0]       sync_q;
	logic             level_q;
	logic [CNT_W-1:0] stable_cnt;

	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			sync_q     <= 2'b11;
			level_q    <= 1'b1;
			stable_cnt <= '0;
			o_neg      <= 1'b0;
		end else begin
			sync_q <= {sync_q[0], i_in};
			o_neg  <= 1'b0;
			if (sync_q[1] == level_q) begin
				// bounce, start counting again
				stable_cnt <= '0;
			end else if (stable_cnt == CNT_W'(DEBOUNCE_CYCLES - 1)) begin
				stable_cnt <= '0;
				level_q    <= sync_q[1];
				// high to low is a press
				o_neg      <= level_q;
			end else begin
				stable_cnt <= stable_cnt + 1'b1;
			end
		end
	end

	// a press needs a release and a full stable count before the next one
	a_neg_single: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		o_neg |=> !o_neg)
		else $error("debounce: o_neg high in consecutive cycles");

endmodule

`default_nettype wire

// File: aud_recorder.sv
`default_nettype none

module aud_recorder (
	input  logic                           i_clk,
	input  logic                           i_rst_n,
	input  logic                           i_en,
	input  logic                           i_aud_bclk,
	input  logic                           i_aud_adclrck,
	input  logic                           i_aud_adcdat,
	output logic [audio_pkg::SAMPLE_W-1:0] o_sample,
	output logic                           o_sample_valid
);
	import audio_pkg::*;

	localparam int CNT_W = $clog2(SAMPLE_W);

	logic [2:0]          bclk_q;
	logic [2:0]          lrck_q;
	logic [1:0]          dat_q;
	logic                bclk_rise;
	logic                lrck_fall;
	logic                active;
	logic                shift_en;
	logic                last_bit;
	logic [CNT_W-1:0]    bit_cnt;
	logic [SAMPLE_W-2:0] shreg;

	// edges seen on the second sync stage
	assign bclk_rise = bclk_q[1] & ~bclk_q[2];
	assign lrck_fall = lrck_q[2] & ~lrck_q[1];
	assign shift_en  = i_en && !lrck_fall && active && bclk_rise;
	assign last_bit  = (bit_cnt == CNT_W'(SAMPLE_W - 1));

	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			bclk_q         <= '0;
			lrck_q         <= '0;
			dat_q          <= '0;
			active         <= 1'b0;
			bit_cnt        <= '0;
			o_sample_valid <= 1'b0;
		end else begin
			bclk_q         <= {bclk_q[1:0], i_aud_bclk};
			lrck_q         <= {lrck_q[1:0], i_aud_adclrck};
			dat_q          <= {dat_q[0], i_aud_adcdat};
			o_sample_valid <= 1'b0;
			if (!i_en) begin
				// a frame only counts if enabled from its start
				active <= 1'b0;
			end else if (lrck_fall) begin
				active  <= 1'b1;
				bit_cnt <= '0;
			end else if (shift_en) begin
				bit_cnt <= bit_cnt + 1'b1;
				if (last_bit) begin
					active         <= 1'b0;
					o_sample_valid <= 1'b1;
				end
			end
		end
	end

	// msb first
	always_ff @(posedge i_clk) begin
		if (shift_en) begin
			shreg <= {shreg[SAMPLE_W-3:0], dat_q[1]};
			if (last_bit)
				o_sample <= {shreg, dat_q[1]};
		end
	end

	a_valid_single: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		o_sample_valid |=> !o_sample_valid)
		else $error("aud_recorder: sample strobe high in consecutive cycles");

endmodule

`default_nettype wire

// File: aud_dsp.sv
`default_nettype none

module aud_dsp (
	input  logic                           i_clk,
	input  logic                           i_rst_n,
	input  logic                           i_start,
	input  logic                           i_run,
	input  audio_pkg::play_mode_t          i_mode,
	input  logic [audio_pkg::SPEED_W-1:0]  i_speed,
	input  logic [audio_pkg::ADDR_W-1:0]   i_length,
	input  logic                           i_frame_start,
	output logic                           o_rd_req,
	output logic [audio_pkg::ADDR_W-1:0]   o_rd_addr,
	input  logic [audio_pkg::SAMPLE_W-1:0] i_rd_data,
	output logic [audio_pkg::SAMPLE_W-1:0] o_dac_sample,
	output logic                           o_done
);
	import audio_pkg::*;

	localparam int FACT_W = SPEED_W + 1;

	typedef enum logic [1:0] {PH_IDLE, PH_RD_A, PH_RD_B, PH_CALC} phase_t;

	phase_t                     phase;
	logic                       primed;
	logic [ADDR_W-1:0]          addr;
	logic [SPEED_W-1:0]         sub_j;
	logic [ADDR_W-1:0]          t_addr;
	logic [SPEED_W-1:0]         t_j;
	logic [ADDR_W:0]            nxt_addr;
	logic [SPEED_W-1:0]         nxt_j;
	logic [FACT_W-1:0]          factor;
	logic [FACT_W-1:0]          w_a;
	logic                       has_next;
	logic signed [SAMPLE_W-1:0] samp_a;
	logic signed [SAMPLE_W-1:0] samp_b;
	logic signed [SAMPLE_W+FACT_W:0] mix_sum;
	logic signed [SAMPLE_W+FACT_W:0] mix_quot;

	assign factor   = FACT_W'(i_speed) + 1'b1;
	assign has_next = ({1'b0, t_addr} + 1'b1) < {1'b0, i_length};

	// next source position
	// the priming frame reads address 0 as is
	always_comb begin
		nxt_addr = {1'b0, addr};
		nxt_j    = '0;
		if (primed) begin
			case (i_mode)
				MODE_FAST: nxt_addr = {1'b0, addr} + (ADDR_W+1)'(factor);
				MODE_SLOW_REPEAT, MODE_SLOW_INTERP: begin
					if (sub_j >= i_speed)
						nxt_addr = {1'b0, addr} + 1'b1;
					else
						nxt_j = sub_j + 1'b1;
				end
				default: nxt_addr = {1'b0, addr} + 1'b1;
			endcase
		end
	end

	// ((f-j)*a + j*b)/f with signed division truncating toward zero
	assign w_a      = factor - FACT_W'(t_j);
	assign mix_sum  = samp_a * $signed({1'b0, w_a}) + samp_b * $signed({2'b00, t_j});
	assign mix_quot = mix_sum / $signed({1'b0, factor});

	assign o_rd_req  = i_run && (phase == PH_RD_A || phase == PH_RD_B);
	assign o_rd_addr = (phase == PH_RD_B) ? t_addr + 1'b1 : t_addr;

	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			phase        <= PH_IDLE;
			primed       <= 1'b0;
			addr         <= '0;
			sub_j        <= '0;
			o_dac_sample <= '0;
			o_done       <= 1'b0;
		end else begin
			o_done <= 1'b0;
			if (i_start) begin
				phase        <= PH_IDLE;
				primed       <= 1'b0;
				addr         <= '0;
				sub_j        <= '0;
				o_dac_sample <= '0;
			end else if (!i_run) begin
				// a pause drops any fetch before it commits
				phase <= PH_IDLE;
			end else begin
				case (phase)
					PH_IDLE: begin
						if (i_frame_start) begin
							if (nxt_addr >= {1'b0, i_length})
								o_done <= 1'b1;
							else
								phase <= PH_RD_A;
						end
					end
					PH_RD_A: begin
						if (i_mode == MODE_SLOW_INTERP && has_next)
							phase <= PH_RD_B;
						else
							phase <= PH_CALC;
					end
					PH_RD_B: phase <= PH_CALC;
					default: begin
						if (i_mode == MODE_SLOW_INTERP)
							o_dac_sample <= mix_quot[SAMPLE_W-1:0];
						else
							o_dac_sample <= samp_a;
						addr   <= t_addr;
						sub_j  <= t_j;
						primed <= 1'b1;
						phase  <= PH_IDLE;
					end
				endcase
			end
		end
	end

	// fetch target and read data
	always_ff @(posedge i_clk) begin
		if (phase == PH_IDLE && i_frame_start) begin
			t_addr <= nxt_addr[ADDR_W-1:0];
			t_j    <= nxt_j;
		end
		if (phase == PH_RD_A) begin
			samp_a <= i_rd_data;
			// last address interpolates against itself
			samp_b <= i_rd_data;
		end
		if (phase == PH_RD_B)
			samp_b <= i_rd_data;
	end

	// reads only while running, in the two cycles after a frame start
	a_rd_only_running: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		o_rd_req |-> i_run && ($past(i_frame_start) || $past(i_frame_start, 2)))
		else $error("aud_dsp: SRAM read outside a running prefetch");

endmodule

`default_nettype wire

// File: aud_player.sv
`default_nettype none

module aud_player (
	input  logic                           i_clk,
	input  logic                           i_rst_n,
	input  logic                           i_en,
	input  logic                           i_aud_bclk,
	input  logic                           i_aud_daclrck,
	input  logic [audio_pkg::SAMPLE_W-1:0] i_dac_sample,
	output logic                           o_frame_start,
	output logic                           o_aud_dacdat
);
	import audio_pkg::*;

	localparam int CNT_W = $clog2(SAMPLE_W + 1);

	logic [2:0]          bclk_q;
	logic [2:0]          lrck_q;
	logic                bclk_fall;
	logic                lrck_fall;
	logic [SAMPLE_W-1:0] frame_sample;
	logic [SAMPLE_W-2:0] shreg;
	logic [CNT_W-1:0]    bit_cnt;

	assign bclk_fall    = bclk_q[2] & ~bclk_q[1];
	assign lrck_fall    = lrck_q[2] & ~lrck_q[1];
	assign frame_sample = i_en ? i_dac_sample : '0;

	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			bclk_q        <= '0;
			lrck_q        <= '0;
			bit_cnt       <= CNT_W'(SAMPLE_W);
			o_frame_start <= 1'b0;
			o_aud_dacdat  <= 1'b0;
		end else begin
			bclk_q        <= {bclk_q[1:0], i_aud_bclk};
			lrck_q        <= {lrck_q[1:0], i_aud_daclrck};
			o_frame_start <= lrck_fall;
			if (lrck_fall) begin
				// msb goes out with the frame edge
				o_aud_dacdat <= frame_sample[SAMPLE_W-1];
				bit_cnt      <= CNT_W'(1);
			end else if (bclk_fall) begin
				if (bit_cnt < CNT_W'(SAMPLE_W)) begin
					o_aud_dacdat <= shreg[SAMPLE_W-2];
					bit_cnt      <= bit_cnt + 1'b1;
				end else begin
					// rest of the frame is silent
					o_aud_dacdat <= 1'b0;
				end
			end
		end
	end

	always_ff @(posedge i_clk) begin
		if (lrck_fall)
			shreg <= frame_sample[SAMPLE_W-2:0];
		else if (bclk_fall)
			shreg <= {shreg[SAMPLE_W-3:0], 1'b0};
	end

endmodule

`default_nettype wire

// File: recorder_core.sv
`default_nettype none

module recorder_core #(
	parameter int MEM_WORDS = 2**20
) (
	input  logic                          i_clk,
	input  logic                          i_rst_n,
	input  logic                          i_key_record,
	input  logic                          i_key_play,
	input  logic                          i_key_stop,
	input  logic [audio_pkg::SPEED_W-1:0] i_speed,
	input  logic                          i_fast,
	input  logic                          i_slow_0,
	input  logic                          i_slow_1,
	output logic [audio_pkg::ADDR_W-1:0]  o_sram_addr,
	inout  wire  [audio_pkg::SAMPLE_W-1:0] io_sram_dq,
	output logic                          o_sram_we_n,
	output logic                          o_sram_ce_n,
	output logic                          o_sram_oe_n,
	output logic                          o_sram_lb_n,
	output logic                          o_sram_ub_n,
	input  logic                          i_aud_bclk,
	input  logic                          i_aud_adclrck,
	input  logic                          i_aud_adcdat,
	input  logic                          i_aud_daclrck,
	output logic                          o_aud_dacdat
);
	import audio_pkg::*;

	rec_state_t          state;
	play_mode_t          play_mode;
	logic [SPEED_W-1:0]  play_speed;
	logic [ADDR_W:0]     rec_cnt;
	logic [ADDR_W-1:0]   rec_len;
	logic                wr_pend;
	logic [SAMPLE_W-1:0] wr_data;
	logic [SAMPLE_W-1:0] adc_sample;
	logic                adc_valid;
	logic                rec_en;
	logic                play_run;
	logic                rec_start;
	logic                play_start;
	logic                mem_full;
	logic                rd_req;
	logic [ADDR_W-1:0]   rd_addr;
	logic [SAMPLE_W-1:0] dac_sample;
	logic                frame_start;
	logic                play_done;

	assign rec_en     = (state == ST_RECORD);
	assign play_run   = (state == ST_PLAY);
	assign rec_start  = (state == ST_IDLE) && i_key_record && !i_key_stop;
	assign play_start = (state == ST_IDLE) && i_key_play && !i_key_record && !i_key_stop;
	assign mem_full   = wr_pend && (rec_cnt == (ADDR_W+1)'(MEM_WORDS - 1));

	// count saturates for a completely full memory
	assign rec_len = rec_cnt[ADDR_W] ? '1 : rec_cnt[ADDR_W-1:0];

	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			state <= ST_IDLE;
		end else if (i_key_stop || mem_full || play_done) begin
			state <= ST_IDLE;
		end else begin
			case (state)
				ST_IDLE: begin
					if (i_key_record)
						state <= ST_RECORD;
					else if (i_key_play)
						state <= ST_PLAY;
				end
				ST_RECORD:       if (i_key_record) state <= ST_RECORD_PAUSE;
				ST_RECORD_PAUSE: if (i_key_record) state <= ST_RECORD;
				ST_PLAY:         if (i_key_play) state <= ST_PLAY_PAUSE;
				ST_PLAY_PAUSE:   if (i_key_play) state <= ST_PLAY;
				default:         state <= ST_IDLE;
			endcase
		end
	end

	// write cycle follows the sample strobe, address steps after it
	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			wr_pend    <= 1'b0;
			rec_cnt    <= '0;
			play_mode  <= MODE_NORMAL;
			play_speed <= '0;
		end else begin
			wr_pend <= adc_valid && rec_en;
			if (rec_start)
				rec_cnt <= '0;
			else if (wr_pend)
				rec_cnt <= rec_cnt + 1'b1;
			if (play_start) begin
				play_speed <= i_speed;
				if (i_fast)
					play_mode <= MODE_FAST;
				else if (i_slow_0)
					play_mode <= MODE_SLOW_REPEAT;
				else if (i_slow_1)
					play_mode <= MODE_SLOW_INTERP;
				else
					play_mode <= MODE_NORMAL;
			end
		end
	end

	always_ff @(posedge i_clk) begin
		if (adc_valid)
			wr_data <= adc_sample;
	end

	// record and play never overlap, so one address mux is enough
	assign o_sram_addr = wr_pend ? rec_cnt[ADDR_W-1:0] : rd_addr;
	assign io_sram_dq  = wr_pend ? wr_data : 'z;
	assign o_sram_we_n = ~wr_pend;
	assign o_sram_oe_n = ~rd_req;
	assign o_sram_ce_n = 1'b0;
	assign o_sram_lb_n = 1'b0;
	assign o_sram_ub_n = 1'b0;

	aud_recorder u_recorder (
		.i_clk          (i_clk),
		.i_rst_n        (i_rst_n),
		.i_en           (rec_en),
		.i_aud_bclk     (i_aud_bclk),
		.i_aud_adclrck  (i_aud_adclrck),
		.i_aud_adcdat   (i_aud_adcdat),
		.o_sample       (adc_sample),
		.o_sample_valid (adc_valid)
	);

	aud_dsp u_dsp (
		.i_clk         (i_clk),
		.i_rst_n       (i_rst_n),
		.i_start       (play_start),
		.i_run         (play_run),
		.i_mode        (play_mode),
		.i_speed       (play_speed),
		.i_length      (rec_len),
		.i_frame_start (frame_start),
		.o_rd_req      (rd_req),
		.o_rd_addr     (rd_addr),
		.i_rd_data     (io_sram_dq),
		.o_dac_sample  (dac_sample),
		.o_done        (play_done)
	);

	aud_player u_player (
		.i_clk         (i_clk),
		.i_rst_n       (i_rst_n),
		.i_en          (play_run),
		.i_aud_bclk    (i_aud_bclk),
		.i_aud_daclrck (i_aud_daclrck),
		.i_dac_sample  (dac_sample),
		.o_frame_start (frame_start),
		.o_aud_dacdat  (o_aud_dacdat)
	);

	// bus contention between the write path and a dsp read
	a_we_oe_excl: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		!(!o_sram_we_n && !o_sram_oe_n))
		else $error("recorder_core: SRAM WE_N and OE_N low together");

endmodule

`default_nettype wire

// File: de2_115_top.sv
`default_nettype none

module de2_115_top #(
	parameter int DEBOUNCE_CYCLES = 16,
	parameter int MEM_WORDS       = 2**20
) (
	input  logic                           i_clk,
	input  logic                           i_rst_n,
	input  logic [2:0]                     i_key,
	input  logic [6:0]                     i_sw,
	output logic [audio_pkg::ADDR_W-1:0]   o_sram_addr,
	inout  wire  [audio_pkg::SAMPLE_W-1:0] io_sram_dq,
	output logic                           o_sram_we_n,
	output logic                           o_sram_ce_n,
	output logic                           o_sram_oe_n,
	output logic                           o_sram_lb_n,
	output logic                           o_sram_ub_n,
	input  logic                           i_aud_bclk,
	input  logic                           i_aud_adclrck,
	input  logic                           i_aud_adcdat,
	input  logic                           i_aud_daclrck,
	output logic                           o_aud_dacdat,
	output logic [6:0]                     o_hex0,
	output logic [6:0]                     o_hex1,
	output logic [6:0]                     o_hex2,
	output logic [6:0]                     o_hex3,
	output logic [6:0]                     o_hex4,
	output logic [6:0]                     o_hex5,
	output logic [6:0]                     o_hex6,
	output logic [6:0]                     o_hex7
);

	logic key_record;
	logic key_play;
	logic key_stop;

	// key 0 record/pause
	debounce #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) u_deb_record (
		.i_clk   (i_clk),
		.i_rst_n (i_rst_n),
		.i_in    (i_key[0]),
		.o_neg   (key_record)
	);

	// key 1 play/pause
	debounce #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) u_deb_play (
		.i_clk   (i_clk),
		.i_rst_n (i_rst_n),
		.i_in    (i_key[1]),
		.o_neg   (key_play)
	);

	// key 2 stop
	debounce #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) u_deb_stop (
		.i_clk   (i_clk),
		.i_rst_n (i_rst_n),
		.i_in    (i_key[2]),
		.o_neg   (key_stop)
	);

	// sw[3:0] speed, sw[4] fast, sw[5] slow repeat, sw[6] slow interpolate
	recorder_core #(.MEM_WORDS(MEM_WORDS)) u_core (
		.i_clk         (i_clk),
		.i_rst_n       (i_rst_n),
		.i_key_record  (key_record),
		.i_key_play    (key_play),
		.i_key_stop    (key_stop),
		.i_speed       (i_sw[3:0]),
		.i_fast        (i_sw[4]),
		.i_slow_0      (i_sw[5]),
		.i_slow_1      (i_sw[6]),
		.o_sram_addr   (o_sram_addr),
		.io_sram_dq    (io_sram_dq),
		.o_sram_we_n   (o_sram_we_n),
		.o_sram_ce_n   (o_sram_ce_n),
		.o_sram_oe_n   (o_sram_oe_n),
		.o_sram_lb_n   (o_sram_lb_n),
		.o_sram_ub_n   (o_sram_ub_n),
		.i_aud_bclk    (i_aud_bclk),
		.i_aud_adclrck (i_aud_adclrck),
		.i_aud_adcdat  (i_aud_adcdat),
		.i_aud_daclrck (i_aud_daclrck),
		.o_aud_dacdat  (o_aud_dacdat)
	);

	// displays unused, segments are active low
	assign o_hex0 = '1;
	assign o_hex1 = '1;
	assign o_hex2 = '1;
	assign o_hex3 = '1;
	assign o_hex4 = '1;
	assign o_hex5 = '1;
	assign o_hex6 = '1;
	assign o_hex7 = '1;

endmodule

`default_nettype wire

// File: tb_sram_model.sv
`default_nettype none

module tb_sram_model #(
	parameter int ADDR_W = 20,
	parameter int DATA_W = 16
) (
	input  wire [ADDR_W-1:0] i_addr,
	inout  wire [DATA_W-1:0] io_dq,
	input  wire              i_we_n,
	input  wire              i_ce_n,
	input  wire              i_oe_n,
	input  wire              i_lb_n,
	input  wire              i_ub_n
);
	timeunit 1ns;
	timeprecision 1ps;

	localparam int HALF_W = DATA_W / 2;

	logic [DATA_W-1:0] mem [0:(2**ADDR_W)-1];

	// write cycle, address and data settle early in the we_n low phase
	always @(negedge i_we_n) begin
		#5;
		if (!i_we_n && !i_ce_n) begin
			if (!i_lb_n)
				mem[i_addr][HALF_W-1:0] = io_dq[HALF_W-1:0];
			if (!i_ub_n)
				mem[i_addr][DATA_W-1:HALF_W] = io_dq[DATA_W-1:HALF_W];
		end
	end

	// asynchronous read, both byte lanes always on the bus
	assign io_dq = (!i_ce_n && !i_oe_n && i_we_n) ? mem[i_addr] : 'z;

endmodule

`default_nettype wire

// File: tb_top.sv
`default_nettype none

module tb_top;
	timeunit 1ns;
	timeprecision 1ps;

	import audio_pkg::*;

	localparam int FRAME_CYCLES = 256;
	localparam int HALF_CYCLES  = 128;
	localparam int KEY_HOLD     = 40;
	localparam int MEM_WORDS    = 64;
	localparam int KEY_RECORD   = 0;
	localparam int KEY_PLAY     = 1;
	localparam int KEY_STOP     = 2;

	logic                clk        = 1'b0;
	logic                rst_n      = 1'b0;
	logic [2:0]          key        = 3'b111;
	logic [6:0]          sw         = '0;
	logic                aud_bclk   = 1'b0;
	logic                aud_lrck   = 1'b1;
	logic                aud_adcdat = 1'b0;
	wire                 dac_dat;
	wire  [ADDR_W-1:0]   sram_addr;
	wire  [SAMPLE_W-1:0] sram_dq;
	wire                 sram_we_n;
	wire                 sram_ce_n;
	wire                 sram_oe_n;
	wire                 sram_lb_n;
	wire                 sram_ub_n;
	wire  [6:0]          hex [0:7];

	// codec model state
	int                  frame_cyc = 200;
	logic [SAMPLE_W-1:0] adc_word  = '0;
	logic [SAMPLE_W-1:0] dac_shift = '0;

	logic [SAMPLE_W-1:0] adc_q[$];
	logic [SAMPLE_W-1:0] dac_q[$];
	logic [ADDR_W-1:0]   wr_addr_q[$];
	logic [SAMPLE_W-1:0] wr_data_q[$];
	logic [SAMPLE_W-1:0] rec_q[$];
	logic [SAMPLE_W-1:0] exp_q[$];

	always #10 clk = ~clk;

	de2_115_top #(
		.MEM_WORDS (MEM_WORDS)
	) u_dut (
		.i_clk         (clk),
		.i_rst_n       (rst_n),
		.i_key         (key),
		.i_sw          (sw),
		.o_sram_addr   (sram_addr),
		.io_sram_dq    (sram_dq),
		.o_sram_we_n   (sram_we_n),
		.o_sram_ce_n   (sram_ce_n),
		.o_sram_oe_n   (sram_oe_n),
		.o_sram_lb_n   (sram_lb_n),
		.o_sram_ub_n   (sram_ub_n),
		.i_aud_bclk    (aud_bclk),
		.i_aud_adclrck (aud_lrck),
		.i_aud_adcdat  (aud_adcdat),
		.i_aud_daclrck (aud_lrck),
		.o_aud_dacdat  (dac_dat),
		.o_hex0        (hex[0]),
		.o_hex1        (hex[1]),
		.o_hex2        (hex[2]),
		.o_hex3        (hex[3]),
		.o_hex4        (hex[4]),
		.o_hex5        (hex[5]),
		.o_hex6        (hex[6]),
		.o_hex7        (hex[7])
	);

	tb_sram_model #(
		.ADDR_W (ADDR_W),
		.DATA_W (SAMPLE_W)
	) u_sram (
		.i_addr (sram_addr),
		.io_dq  (sram_dq),
		.i_we_n (sram_we_n),
		.i_ce_n (sram_ce_n),
		.i_oe_n (sram_oe_n),
		.i_lb_n (sram_lb_n),
		.i_ub_n (sram_ub_n)
	);

	// codec: bit clock every 4 cycles, left half is the low lr clock half
	always @(posedge clk) begin
		#2;
		frame_cyc = (frame_cyc + 1) % FRAME_CYCLES;
		if (frame_cyc == 0) begin
			adc_word = 16'($urandom());
			adc_q.push_back(adc_word);
		end
		aud_bclk   = 1'((frame_cyc / 4) % 2);
		aud_lrck   = (frame_cyc >= HALF_CYCLES);
		aud_adcdat = (frame_cyc < HALF_CYCLES) ? adc_word[15 - frame_cyc / 8] : 1'b0;
		// dac bits taken on rising bit clock edges
		if (frame_cyc < HALF_CYCLES && frame_cyc % 8 == 4) begin
			dac_shift = {dac_shift[SAMPLE_W-2:0], dac_dat};
			if (frame_cyc == HALF_CYCLES - 4)
				dac_q.push_back(dac_shift);
		end
	end

	// every SRAM write cycle as seen on the pins
	always @(negedge clk) begin
		if (rst_n && !sram_we_n) begin
			wr_addr_q.push_back(sram_addr);
			wr_data_q.push_back(sram_dq);
		end
	end

	task automatic check_value(input string name, input logic [63:0] got,
		input logic [63:0] exp);
		if (got !== exp) begin
			$display("CHECK FAILED at %0t ns: %s = 0x%0h, expected 0x%0h",
				$time, name, got, exp);
			$display("SOME TESTS FAILED");
			$fatal(1, "stopped at the first mismatch");
		end
	endtask

	task automatic report_timeout(input string what);
		$display("timeout at %0t ns while waiting for %s", $time, what);
		$display("SOME TESTS FAILED");
		$fatal(1, "stopped after a timeout");
	endtask

	task automatic sync_to_cycle(input int target);
		int cycles;
		cycles = 0;
		do begin
			@(posedge clk);
			cycles++;
		end while (frame_cyc != target && cycles < FRAME_CYCLES + 4);
		if (frame_cyc != target)
			report_timeout("the codec frame position");
	endtask

	// press in the right half so the action lands before the next frame edge
	task automatic press_key(input int idx);
		sync_to_cycle(HALF_CYCLES - 1);
		#2;
		key[idx] = 1'b0;
		repeat (KEY_HOLD) @(posedge clk);
		#2;
		key[idx] = 1'b1;
		repeat (KEY_HOLD) @(posedge clk);
	endtask

	task automatic set_switches(input logic [6:0] value);
		@(posedge clk);
		#2;
		sw = value;
	endtask

	task automatic clear_logs();
		adc_q.delete();
		dac_q.delete();
		wr_addr_q.delete();
		wr_data_q.delete();
	endtask

	task automatic settle_frames(input int n);
		repeat (n * FRAME_CYCLES) @(posedge clk);
	endtask

	task automatic collect_adc(input int n);
		int cycles;
		cycles = 0;
		while (adc_q.size() < n && cycles < (n + 2) * FRAME_CYCLES) begin
			@(posedge clk);
			cycles++;
		end
		if (adc_q.size() < n)
			report_timeout("ADC frames");
	endtask

	task automatic collect_dac(input int n);
		int cycles;
		cycles = 0;
		while (dac_q.size() < n && cycles < (n + 2) * FRAME_CYCLES) begin
			@(posedge clk);
			cycles++;
		end
		if (dac_q.size() < n)
			report_timeout("DAC frames");
	endtask

	task automatic collect_writes(input int n);
		int cycles;
		cycles = 0;
		while (wr_addr_q.size() < n && cycles < (n + 4) * FRAME_CYCLES) begin
			@(posedge clk);
			cycles++;
		end
		if (wr_addr_q.size() < n)
			report_timeout("SRAM writes");
	endtask

	// the recording is adc_q[first] to adc_q[last]
	task automatic take_samples(input int first, input int last);
		for (int i = first; i <= last; i++)
			rec_q.push_back(adc_q[i]);
	endtask

	task automatic compare_writes();
		check_value("SRAM write count", wr_addr_q.size(), rec_q.size());
		for (int i = 0; i < rec_q.size(); i++) begin
			check_value($sformatf("o_sram_addr write %0d", i), wr_addr_q[i], i);
			check_value($sformatf("io_sram_dq write %0d", i), wr_data_q[i], rec_q[i]);
		end
	endtask

	task automatic compare_dac();
		for (int i = 0; i < exp_q.size(); i++)
			check_value($sformatf("o_aud_dacdat word %0d", i), dac_q[i], exp_q[i]);
	endtask

	// priming zero, the mode's sample sequence, then silence
	task automatic build_expected(input play_mode_t mode, input int factor);
		int len;
		int a;
		int j;
		int av;
		int bv;
		len = rec_q.size();
		exp_q.delete();
		exp_q.push_back('0);
		case (mode)
			MODE_FAST: begin
				for (a = 0; a < len; a += factor)
					exp_q.push_back(rec_q[a]);
			end
			MODE_SLOW_REPEAT: begin
				for (a = 0; a < len; a++)
					repeat (factor) exp_q.push_back(rec_q[a]);
			end
			MODE_SLOW_INTERP: begin
				for (a = 0; a < len; a++) begin
					av = int'($signed(rec_q[a]));
					bv = (a + 1 < len) ? int'($signed(rec_q[a + 1])) : av;
					for (j = 0; j < factor; j++)
						exp_q.push_back(16'(((factor - j) * av + j * bv) / factor));
				end
			end
			default: begin
				for (a = 0; a < len; a++)
					exp_q.push_back(rec_q[a]);
			end
		endcase
		exp_q.push_back('0);
		exp_q.push_back('0);
	endtask

	task automatic play_and_compare(input logic [6:0] sw_value);
		set_switches(sw_value);
		press_key(KEY_PLAY);
		clear_logs();
		collect_dac(exp_q.size());
		compare_dac();
		check_value("SRAM writes during playback", wr_addr_q.size(), 0);
		set_switches('0);
	endtask

	initial begin
		void'($urandom(43963));
		rst_n = 1'b0;
		key   = 3'b111;
		sw    = '0;
		repeat (10) @(posedge clk);
		#2;
		rst_n = 1'b1;
		@(negedge clk);
		check_value("o_sram_we_n", sram_we_n, 1);
		check_value("o_sram_oe_n", sram_oe_n, 1);
		check_value("o_sram_ce_n", sram_ce_n, 0);
		check_value("o_sram_lb_n", sram_lb_n, 0);
		check_value("o_sram_ub_n", sram_ub_n, 0);
		check_value("o_aud_dacdat", dac_dat, 0);
		for (int i = 0; i < 8; i++)
			check_value($sformatf("o_hex%0d", i), hex[i], 7'h7f);
		settle_frames(2);

		// plain recording of 20 frames
		press_key(KEY_RECORD);
		clear_logs();
		collect_adc(20);
		press_key(KEY_STOP);
		settle_frames(3);
		rec_q.delete();
		take_samples(0, 19);
		compare_writes();

		// playback modes on the 20 sample recording
		build_expected(MODE_NORMAL, 1);
		play_and_compare(7'b0000000);
		build_expected(MODE_FAST, 3);
		play_and_compare(7'b0010010);
		build_expected(MODE_SLOW_REPEAT, 4);
		play_and_compare(7'b0100011);
		build_expected(MODE_SLOW_INTERP, 4);
		play_and_compare(7'b1000011);

		// recording paused after frame 5, resumed after frame 8
		press_key(KEY_RECORD);
		clear_logs();
		collect_adc(5);
		press_key(KEY_RECORD);
		collect_adc(8);
		press_key(KEY_RECORD);
		collect_adc(12);
		press_key(KEY_STOP);
		settle_frames(3);
		rec_q.delete();
		take_samples(0, 4);
		take_samples(8, 11);
		compare_writes();

		// playback paused for three frames, silent while paused
		exp_q.delete();
		exp_q.push_back('0);
		for (int i = 0; i < 3; i++)
			exp_q.push_back(rec_q[i]);
		repeat (3) exp_q.push_back('0);
		for (int i = 3; i < 9; i++)
			exp_q.push_back(rec_q[i]);
		repeat (2) exp_q.push_back('0);
		press_key(KEY_PLAY);
		clear_logs();
		collect_dac(4);
		press_key(KEY_PLAY);
		collect_dac(7);
		press_key(KEY_PLAY);
		collect_dac(exp_q.size());
		compare_dac();

		// long recording runs into the memory limit
		press_key(KEY_RECORD);
		clear_logs();
		collect_writes(MEM_WORDS);
		settle_frames(3);
		rec_q.delete();
		take_samples(0, MEM_WORDS - 1);
		compare_writes();

		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// File: project.f
audio_pkg.sv
debounce.sv
aud_recorder.sv
aud_dsp.sv
aud_player.sv
recorder_core.sv
de2_115_top.sv
tb_sram_model.sv
tb_top.sv

// File: Makefile
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_top \
		-f project.f -Mdir obj_dir -o tb_top
	./obj_dir/tb_top

clean:
	rm -rf obj_dir
